//--- common/mem_pkg.sv
package mem_pkg;

	// Data cache geometry, one 32-bit word per line
	localparam int DCACHE_INDEX_BITS = 8;
	localparam int DCACHE_LINES = 1 << DCACHE_INDEX_BITS;
	localparam int DCACHE_TAG_BITS = 32 - DCACHE_INDEX_BITS - 2;

	// Address bits 31:28 of the cached SDRAM window
	localparam logic [3:0] CACHEABLE_REGION = 4'h2;

	typedef enum logic [1:0] {
		MEM_NONE,
		MEM_READ,
		MEM_WRITE,
		MEM_FLUSH
	} mem_op_e;

	typedef enum logic [1:0] {
		MEM_BYTE,
		MEM_HALF,
		MEM_WORD
	} mem_width_e;

	typedef struct packed {
		logic [3:0] tag;
		mem_op_e op;
		mem_width_e width;
		logic is_signed;
		logic [31:0] address;
		logic [31:0] rd;
		logic [4:0] inst_rd;
	} exec_to_mem_t;

	typedef struct packed {
		logic [3:0] tag;
		logic [31:0] rd;
		logic [4:0] inst_rd;
	} mem_to_wb_t;

	typedef struct packed {
		logic rw;
		logic flush;
		logic [31:0] address;
		logic [31:0] wdata;
	} cache_req_t;

	typedef struct packed {
		logic rw;
		logic [31:0] address;
		logic [31:0] wdata;
	} bus_req_t;

	typedef struct packed {
		logic [DCACHE_TAG_BITS-1:0] tag;
		logic [DCACHE_INDEX_BITS-1:0] index;
		logic [1:0] offset;
	} cache_addr_fields_t;

	// Same address seen flat or split for the cache lookup
	typedef union packed {
		logic [31:0] word;
		cache_addr_fields_t fields;
	} cache_addr_u;

endpackage

//--- mem_access/mem_access.sv
`timescale 1ns/1ps

module mem_access (
	input  logic i_clock,
	input  logic i_arst_n,

	// Execute stage side
	input  mem_pkg::exec_to_mem_t i_exec,
	output logic o_busy,
	output mem_pkg::mem_to_wb_t o_result,

	// Data cache side
	output logic o_cache_request,
	output mem_pkg::cache_req_t o_cache_req,
	input  logic i_cache_ready,
	input  logic [31:0] i_cache_rdata
);

	typedef enum logic [2:0] {
		IDLE,
		READ,
		WRITE_WORD,
		RMW_READ,
		RMW_WRITE,
		FLUSH
	} state_t;

	state_t state;
	logic new_op;
	logic [1:0] byte_offset;
	logic [31:0] aligned_address;
	logic [31:0] rdata_shifted;
	logic [31:0] load_value;
	logic [31:0] merged_word;

	function automatic mem_pkg::mem_to_wb_t make_result(
		input mem_pkg::exec_to_mem_t exec,
		input logic [31:0] value
	);
		mem_pkg::mem_to_wb_t wb;
		wb.tag = exec.tag;
		wb.rd = value;
		wb.inst_rd = exec.inst_rd;
		return wb;
	endfunction

	// A tag differing from the last result means a fresh operation
	assign new_op = (i_exec.tag != o_result.tag);
	assign o_busy = new_op || (state != IDLE);

	assign byte_offset = i_exec.address[1:0];
	assign aligned_address = {i_exec.address[31:2], 2'b00};
	assign rdata_shifted = i_cache_rdata >> {byte_offset, 3'b000};

	always_comb begin
		case (i_exec.width)
			mem_pkg::MEM_BYTE:
				load_value = {{24{i_exec.is_signed & rdata_shifted[7]}}, rdata_shifted[7:0]};
			mem_pkg::MEM_HALF:
				load_value = {{16{i_exec.is_signed & rdata_shifted[15]}}, rdata_shifted[15:0]};
			default:
				load_value = i_cache_rdata;
		endcase
	end

	// Store byte or half dropped into the fetched word
	always_comb begin
		merged_word = i_cache_rdata;
		case (i_exec.width)
			mem_pkg::MEM_BYTE:
				merged_word[{byte_offset, 3'b000} +: 8] = i_exec.rd[7:0];
			mem_pkg::MEM_HALF:
				merged_word[{byte_offset[1], 4'b0000} +: 16] = i_exec.rd[15:0];
			default:
				merged_word = i_exec.rd;
		endcase
	end

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state <= IDLE;
			o_result <= '0;
			o_cache_request <= 1'b0;
			o_cache_req <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (new_op) begin
						o_cache_req.address <= aligned_address;
						o_cache_req.wdata <= i_exec.rd;
						o_cache_req.rw <= 1'b0;
						o_cache_req.flush <= 1'b0;
						case (i_exec.op)
							mem_pkg::MEM_READ: begin
								o_cache_request <= 1'b1;
								state <= READ;
							end
							mem_pkg::MEM_WRITE: begin
								o_cache_request <= 1'b1;
								if (i_exec.width == mem_pkg::MEM_WORD) begin
									o_cache_req.rw <= 1'b1;
									state <= WRITE_WORD;
								end else begin
									// Partial store, fetch the word first
									state <= RMW_READ;
								end
							end
							mem_pkg::MEM_FLUSH: begin
								o_cache_request <= 1'b1;
								o_cache_req.flush <= 1'b1;
								state <= FLUSH;
							end
							default: begin
								o_result <= make_result(i_exec, i_exec.rd);
							end
						endcase
					end
				end

				READ: begin
					if (i_cache_ready) begin
						o_cache_request <= 1'b0;
						o_result <= make_result(i_exec, load_value);
						state <= IDLE;
					end
				end

				WRITE_WORD, FLUSH: begin
					if (i_cache_ready) begin
						o_cache_request <= 1'b0;
						o_cache_req.rw <= 1'b0;
						o_cache_req.flush <= 1'b0;
						o_result <= make_result(i_exec, i_exec.rd);
						state <= IDLE;
					end
				end

				RMW_READ: begin
					if (i_cache_ready) begin
						o_cache_request <= 1'b0;
						o_cache_req.wdata <= merged_word;
						o_cache_req.rw <= 1'b1;
						state <= RMW_WRITE;
					end
				end

				RMW_WRITE: begin
					// Request stays low one cycle after the read completes
					if (!o_cache_request) begin
						o_cache_request <= 1'b1;
					end else if (i_cache_ready) begin
						o_cache_request <= 1'b0;
						o_cache_req.rw <= 1'b0;
						o_result <= make_result(i_exec, i_exec.rd);
						state <= IDLE;
					end
				end

				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Execute stage only hands over aligned half words
	half_aligned_a: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		o_busy && (i_exec.op inside {mem_pkg::MEM_READ, mem_pkg::MEM_WRITE})
			&& (i_exec.width == mem_pkg::MEM_HALF) |-> !i_exec.address[0]);

	cache_req_hold_a: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		o_cache_request && !i_cache_ready |=> o_cache_request && $stable(o_cache_req));

endmodule

//--- dcache/dcache.sv
`timescale 1ns/1ps

module dcache (
	input  logic i_clock,
	input  logic i_arst_n,

	// Memory stage side
	input  logic i_request,
	input  mem_pkg::cache_req_t i_req,
	output logic o_ready,
	output logic [31:0] o_rdata,

	// External bus
	output logic o_bus_request,
	output mem_pkg::bus_req_t o_bus,
	input  logic i_bus_ready,
	input  logic [31:0] i_bus_rdata
);

	typedef enum logic [1:0] {
		IDLE,
		BUS,
		DONE
	} state_t;

	state_t state;
	mem_pkg::cache_addr_u req_addr;
	logic cacheable;
	logic hit;
	logic line_write;
	logic [31:0] line_wdata;

	logic [mem_pkg::DCACHE_LINES-1:0] valid;
	logic [mem_pkg::DCACHE_TAG_BITS-1:0] tag_mem [mem_pkg::DCACHE_LINES];
	logic [31:0] data_mem [mem_pkg::DCACHE_LINES];

	assign req_addr.word = i_req.address;

	// Only the SDRAM window goes through the arrays
	assign cacheable = (req_addr.word[31:28] == mem_pkg::CACHEABLE_REGION);

	assign hit = cacheable
		&& valid[req_addr.fields.index]
		&& (tag_mem[req_addr.fields.index] == req_addr.fields.tag);

	// Fill on cacheable read miss, update on write hit
	always_comb begin
		line_write = 1'b0;
		line_wdata = i_bus_rdata;
		if ((state == BUS) && i_bus_ready && cacheable) begin
			if (i_req.rw) begin
				line_write = hit;
				line_wdata = i_req.wdata;
			end else begin
				line_write = 1'b1;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (line_write) begin
			tag_mem[req_addr.fields.index] <= req_addr.fields.tag;
			data_mem[req_addr.fields.index] <= line_wdata;
		end
	end

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state <= IDLE;
			valid <= '0;
			o_ready <= 1'b0;
			o_rdata <= '0;
			o_bus_request <= 1'b0;
			o_bus <= '0;
		end else begin
			o_ready <= 1'b0;
			case (state)
				IDLE: begin
					if (i_request) begin
						if (i_req.flush) begin
							valid <= '0;
							o_ready <= 1'b1;
							state <= DONE;
						end else if (!i_req.rw && hit) begin
							o_rdata <= data_mem[req_addr.fields.index];
							o_ready <= 1'b1;
							state <= DONE;
						end else begin
							// Miss, uncached access or store
							o_bus_request <= 1'b1;
							o_bus.rw <= i_req.rw;
							o_bus.address <= i_req.address;
							o_bus.wdata <= i_req.wdata;
							state <= BUS;
						end
					end
				end

				BUS: begin
					if (i_bus_ready) begin
						o_bus_request <= 1'b0;
						o_rdata <= i_bus_rdata;
						o_ready <= 1'b1;
						if (line_write) begin
							valid[req_addr.fields.index] <= 1'b1;
						end
						state <= DONE;
					end
				end

				DONE: begin
					// Requester drops its request here
					state <= IDLE;
				end

				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	bus_req_hold_a: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		o_bus_request && !i_bus_ready |=> o_bus_request && $stable(o_bus));

endmodule

//--- rtl/mem_stage_top.sv
`timescale 1ns/1ps

module mem_stage_top (
	input  logic i_clock,
	input  logic i_arst_n,

	// Pipeline
	input  mem_pkg::exec_to_mem_t i_exec,
	output logic o_busy,
	output mem_pkg::mem_to_wb_t o_result,

	// External bus
	output logic o_bus_request,
	output mem_pkg::bus_req_t o_bus,
	input  logic i_bus_ready,
	input  logic [31:0] i_bus_rdata
);

	logic cache_request;
	mem_pkg::cache_req_t cache_req;
	logic cache_ready;
	logic [31:0] cache_rdata;

	mem_access mem_access_i (
		.i_clock(i_clock),
		.i_arst_n(i_arst_n),
		.i_exec(i_exec),
		.o_busy(o_busy),
		.o_result(o_result),
		.o_cache_request(cache_request),
		.o_cache_req(cache_req),
		.i_cache_ready(cache_ready),
		.i_cache_rdata(cache_rdata)
	);

	dcache dcache_i (
		.i_clock(i_clock),
		.i_arst_n(i_arst_n),
		.i_request(cache_request),
		.i_req(cache_req),
		.o_ready(cache_ready),
		.o_rdata(cache_rdata),
		.o_bus_request(o_bus_request),
		.o_bus(o_bus),
		.i_bus_ready(i_bus_ready),
		.i_bus_rdata(i_bus_rdata)
	);

endmodule

//--- verif/bus_memory_model.sv
`timescale 1ns/1ps

module bus_memory_model (
	input  logic i_clock,
	input  logic i_arst_n,

	// External bus, slave side
	input  logic i_bus_request,
	input  mem_pkg::bus_req_t i_bus,
	output logic o_bus_ready,
	output logic [31:0] o_bus_rdata,

	// Number of completed bus reads
	output int o_read_count
);

	logic [31:0] mem [1024];
	integer seed = 32'h8027;
	logic waiting;
	logic [1:0] count;

	// Known word for every index, built from all index bits
	function automatic logic [31:0] fill_word(input logic [9:0] index);
		return 32'h9C5A_E3B7 ^ {index, 2'b00, index, 2'b00, index[7:0]};
	endfunction

	always @(posedge i_clock or negedge i_arst_n) begin : bus_response
		int draw;
		logic start_now;
		if (!i_arst_n) begin
			o_bus_ready <= 1'b0;
			o_bus_rdata <= '0;
			o_read_count <= 0;
			waiting <= 1'b0;
			count <= '0;
			for (int i = 0; i < 1024; i++) begin
				mem[i] <= fill_word(10'(i));
			end
		end else begin
			o_bus_ready <= 1'b0;
			start_now = 1'b0;
			if (i_bus_request && !o_bus_ready) begin
				if (!waiting) begin
					// Random wait of 0 to 3 cycles
					draw = $random(seed);
					if (draw[1:0] == 2'd0) begin
						start_now = 1'b1;
					end else begin
						waiting <= 1'b1;
						count <= draw[1:0] - 2'd1;
					end
				end else if (count == 2'd0) begin
					waiting <= 1'b0;
					start_now = 1'b1;
				end else begin
					count <= count - 2'd1;
				end
			end
			if (start_now) begin
				o_bus_ready <= 1'b1;
				if (i_bus.rw) begin
					mem[i_bus.address[11:2]] <= i_bus.wdata;
				end else begin
					o_bus_rdata <= mem[i_bus.address[11:2]];
					o_read_count <= o_read_count + 1;
				end
			end
		end
	end

endmodule

//--- verif/tb_mem_stage.sv
`timescale 1ns/1ps

module tb_mem_stage;

	localparam int NUM_ROWS = 36;
	localparam int CYCLE_LIMIT = NUM_ROWS * 20;
	localparam logic [1:0] READS_ANY = 2'b11;

	// Word addresses, distinct in the model's index bits
	localparam logic [31:0] ADDR_A = 32'h2000_0040;
	localparam logic [31:0] ADDR_B = 32'h1000_0080;
	localparam logic [31:0] ADDR_C = 32'h2000_0100;
	localparam logic [31:0] ADDR_D = 32'h1000_0180;
	localparam logic [31:0] ADDR_E = 32'h2000_0200;
	localparam logic [31:0] ADDR_F = 32'h1000_0300;

	typedef struct packed {
		mem_pkg::mem_op_e op;
		mem_pkg::mem_width_e width;
		logic is_signed;
		logic [31:0] address;
		logic [31:0] wdata;
		logic [31:0] exp_rd;
		logic [1:0] exp_reads;
	} row_t;

	logic clock;
	logic arst_n;
	mem_pkg::exec_to_mem_t exec;
	logic busy;
	mem_pkg::mem_to_wb_t result;
	logic bus_request;
	mem_pkg::bus_req_t bus;
	logic bus_ready;
	logic [31:0] bus_rdata;
	int read_count;

	row_t table_rows [NUM_ROWS];
	int row_count;
	int result_errors;
	int busy_errors;
	int count_errors;
	int cycle_count;
	logic [3:0] tag;

	mem_stage_top dut_i (
		.i_clock(clock),
		.i_arst_n(arst_n),
		.i_exec(exec),
		.o_busy(busy),
		.o_result(result),
		.o_bus_request(bus_request),
		.o_bus(bus),
		.i_bus_ready(bus_ready),
		.i_bus_rdata(bus_rdata)
	);

	bus_memory_model memory_i (
		.i_clock(clock),
		.i_arst_n(arst_n),
		.i_bus_request(bus_request),
		.i_bus(bus),
		.o_bus_ready(bus_ready),
		.o_bus_rdata(bus_rdata),
		.o_read_count(read_count)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#50 clock = ~clock;
		end
	end

	initial begin : watchdog
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("timeout: DUT never finished a table row");
		$display("ERRORS FOUND");
		$finish;
	end

	// Word the memory model holds after reset
	function automatic logic [31:0] preload_word(input logic [31:0] address);
		logic [9:0] index;
		index = address[11:2];
		return 32'h9C5A_E3B7 ^ {index, 2'b00, index, 2'b00, index[7:0]};
	endfunction

	function automatic logic [31:0] load_extend(input logic [31:0] word,
			input logic [31:0] address, input mem_pkg::mem_width_e width,
			input logic is_signed);
		logic [7:0] sel_byte;
		logic [15:0] sel_half;
		logic [31:0] value;
		case (address[1:0])
			2'd0: sel_byte = word[7:0];
			2'd1: sel_byte = word[15:8];
			2'd2: sel_byte = word[23:16];
			default: sel_byte = word[31:24];
		endcase
		sel_half = address[1] ? word[31:16] : word[15:0];
		if (width == mem_pkg::MEM_BYTE) begin
			value = is_signed ? {{24{sel_byte[7]}}, sel_byte} : {24'h0, sel_byte};
		end else if (width == mem_pkg::MEM_HALF) begin
			value = is_signed ? {{16{sel_half[15]}}, sel_half} : {16'h0, sel_half};
		end else begin
			value = word;
		end
		return value;
	endfunction

	function automatic logic [31:0] store_merge(input logic [31:0] word,
			input logic [31:0] address, input mem_pkg::mem_width_e width,
			input logic [31:0] data);
		logic [31:0] merged;
		merged = word;
		if (width == mem_pkg::MEM_BYTE) begin
			case (address[1:0])
				2'd0: merged[7:0] = data[7:0];
				2'd1: merged[15:8] = data[7:0];
				2'd2: merged[23:16] = data[7:0];
				default: merged[31:24] = data[7:0];
			endcase
		end else if (width == mem_pkg::MEM_HALF) begin
			if (address[1]) begin
				merged[31:16] = data[15:0];
			end else begin
				merged[15:0] = data[15:0];
			end
		end else begin
			merged = data;
		end
		return merged;
	endfunction

	task automatic add_row(input mem_pkg::mem_op_e op, input mem_pkg::mem_width_e width,
			input logic is_signed, input logic [31:0] address, input logic [31:0] wdata,
			input logic [31:0] exp_rd, input logic [1:0] exp_reads);
		row_t row;
		row.op = op;
		row.width = width;
		row.is_signed = is_signed;
		row.address = address;
		row.wdata = wdata;
		row.exp_rd = exp_rd;
		row.exp_reads = exp_reads;
		if (row_count < NUM_ROWS) begin
			table_rows[row_count] = row;
		end
		row_count++;
	endtask

	// Load of an untouched word, expected value from the preload
	task automatic add_preload_load(input mem_pkg::mem_width_e width, input logic is_signed,
			input logic [31:0] address, input logic [1:0] exp_reads);
		add_row(mem_pkg::MEM_READ, width, is_signed, address, '0,
			load_extend(preload_word(address), address, width, is_signed), exp_reads);
	endtask

	task automatic build_table();
		logic [31:0] word_e1;
		logic [31:0] word_e2;
		logic [31:0] word_f1;
		logic [31:0] word_f2;
		word_e1 = store_merge(preload_word(ADDR_E), ADDR_E + 1, mem_pkg::MEM_BYTE, 32'hAB);
		word_e2 = store_merge(word_e1, ADDR_E + 2, mem_pkg::MEM_HALF, 32'h7E55);
		word_f1 = store_merge(preload_word(ADDR_F), ADDR_F + 3, mem_pkg::MEM_BYTE, 32'h5C);
		word_f2 = store_merge(word_f1, ADDR_F, mem_pkg::MEM_HALF, 32'h1357);

		add_row(mem_pkg::MEM_NONE, mem_pkg::MEM_WORD, 1'b0, '0, 32'h1234_5678, 32'h1234_5678, 2'd0);

		// Word store then loads, cached and uncached
		add_row(mem_pkg::MEM_WRITE, mem_pkg::MEM_WORD, 1'b0, ADDR_A, 32'hDEAD_BEEF,
			32'hDEAD_BEEF, READS_ANY);
		add_row(mem_pkg::MEM_READ, mem_pkg::MEM_WORD, 1'b0, ADDR_A, '0, 32'hDEAD_BEEF, 2'd1);
		add_row(mem_pkg::MEM_READ, mem_pkg::MEM_WORD, 1'b0, ADDR_A, '0, 32'hDEAD_BEEF, 2'd0);
		add_row(mem_pkg::MEM_WRITE, mem_pkg::MEM_WORD, 1'b0, ADDR_A, 32'h0BAD_F00D,
			32'h0BAD_F00D, 2'd0);
		add_row(mem_pkg::MEM_READ, mem_pkg::MEM_WORD, 1'b0, ADDR_A, '0, 32'h0BAD_F00D, 2'd0);
		add_row(mem_pkg::MEM_WRITE, mem_pkg::MEM_WORD, 1'b0, ADDR_B, 32'hCAFE_1234,
			32'hCAFE_1234, 2'd0);
		add_row(mem_pkg::MEM_READ, mem_pkg::MEM_WORD, 1'b0, ADDR_B, '0, 32'hCAFE_1234, 2'd1);
		add_row(mem_pkg::MEM_READ, mem_pkg::MEM_WORD, 1'b0, ADDR_B, '0, 32'hCAFE_1234, 2'd1);

		// Byte and half loads at every legal offset
		add_preload_load(mem_pkg::MEM_BYTE, 1'b1, ADDR_C, 2'd1);
		add_preload_load(mem_pkg::MEM_BYTE, 1'b0, ADDR_C, 2'd0);
		add_preload_load(mem_pkg::MEM_BYTE, 1'b1, ADDR_C + 1, 2'd0);
		add_preload_load(mem_pkg::MEM_BYTE, 1'b1, ADDR_C + 2, 2'd0);
		add_preload_load(mem_pkg::MEM_BYTE, 1'b0, ADDR_C + 3, 2'd0);
		add_preload_load(mem_pkg::MEM_HALF, 1'b1, ADDR_C, 2'd0);
		add_preload_load(mem_pkg::MEM_HALF, 1'b0, ADDR_C + 2, 2'd0);
		add_preload_load(mem_pkg::MEM_HALF, 1'b1, ADDR_C + 2, 2'd0);
		add_preload_load(mem_pkg::MEM_BYTE, 1'b1, ADDR_D + 1, 2'd1);
		add_preload_load(mem_pkg::MEM_BYTE, 1'b0, ADDR_D + 3, 2'd1);
		add_preload_load(mem_pkg::MEM_HALF, 1'b1, ADDR_D + 2, 2'd1);

		// Flush forces refetch of the same values
		add_row(mem_pkg::MEM_FLUSH, mem_pkg::MEM_WORD, 1'b0, '0, '0, '0, 2'd0);
		add_preload_load(mem_pkg::MEM_WORD, 1'b0, ADDR_C, 2'd1);
		add_row(mem_pkg::MEM_READ, mem_pkg::MEM_WORD, 1'b0, ADDR_A, '0, 32'h0BAD_F00D, 2'd1);
		add_row(mem_pkg::MEM_READ, mem_pkg::MEM_WORD, 1'b0, ADDR_A, '0, 32'h0BAD_F00D, 2'd0);

		// Partial stores keep the other bytes
		add_row(mem_pkg::MEM_WRITE, mem_pkg::MEM_BYTE, 1'b0, ADDR_E + 1, 32'hAB, 32'hAB, 2'd1);
		add_row(mem_pkg::MEM_READ, mem_pkg::MEM_WORD, 1'b0, ADDR_E, '0, word_e1, 2'd0);
		add_row(mem_pkg::MEM_WRITE, mem_pkg::MEM_HALF, 1'b0, ADDR_E + 2, 32'h7E55,
			32'h7E55, 2'd0);
		add_row(mem_pkg::MEM_READ, mem_pkg::MEM_WORD, 1'b0, ADDR_E, '0, word_e2, 2'd0);
		add_row(mem_pkg::MEM_WRITE, mem_pkg::MEM_BYTE, 1'b0, ADDR_F + 3, 32'h5C, 32'h5C, 2'd1);
		add_row(mem_pkg::MEM_READ, mem_pkg::MEM_WORD, 1'b0, ADDR_F, '0, word_f1, 2'd1);
		add_row(mem_pkg::MEM_WRITE, mem_pkg::MEM_HALF, 1'b0, ADDR_F, 32'h1357, 32'h1357, 2'd1);
		add_row(mem_pkg::MEM_READ, mem_pkg::MEM_WORD, 1'b0, ADDR_F, '0, word_f2, 2'd1);
		add_row(mem_pkg::MEM_FLUSH, mem_pkg::MEM_WORD, 1'b0, '0, '0, '0, 2'd0);
		add_row(mem_pkg::MEM_READ, mem_pkg::MEM_WORD, 1'b0, ADDR_E, '0, word_e2, 2'd1);
		add_row(mem_pkg::MEM_READ, mem_pkg::MEM_HALF, 1'b1, ADDR_E + 2, '0,
			load_extend(word_e2, ADDR_E + 2, mem_pkg::MEM_HALF, 1'b1), 2'd0);

		add_row(mem_pkg::MEM_NONE, mem_pkg::MEM_WORD, 1'b0, '0, 32'hFFFF_0000, 32'hFFFF_0000, 2'd0);
	endtask

	task automatic compare_result(input mem_pkg::mem_to_wb_t actual,
			input mem_pkg::mem_to_wb_t expected, input int row);
		if (actual !== expected) begin
			result_errors++;
			$display("ERR %0t: row %0d tag %h rd %h inst_rd %0d, expected tag %h rd %h inst_rd %0d",
				$time, row, actual.tag, actual.rd, actual.inst_rd,
				expected.tag, expected.rd, expected.inst_rd);
		end
	endtask

	task automatic compare_busy(input logic actual, input logic expected, input int row);
		if (actual !== expected) begin
			busy_errors++;
			$display("ERR %0t: row %0d busy %b while result tag is old, expected %b",
				$time, row, actual, expected);
		end
	endtask

	task automatic compare_count(input int actual, input logic [1:0] expected, input int row);
		if ((expected != READS_ANY) && (actual != int'(expected))) begin
			count_errors++;
			$display("ERR %0t: row %0d made %0d bus reads, expected %0d",
				$time, row, actual, expected);
		end
	endtask

	task automatic run_row(input int n);
		int reads_before;
		mem_pkg::mem_to_wb_t expected;
		tag = tag + 4'd1;
		reads_before = read_count;
		exec.tag = tag;
		exec.op = table_rows[n].op;
		exec.width = table_rows[n].width;
		exec.is_signed = table_rows[n].is_signed;
		exec.address = table_rows[n].address;
		exec.rd = table_rows[n].wdata;
		exec.inst_rd = 5'(n + 1);
		@(negedge clock);
		while (!((result.tag == tag) && !busy)) begin
			// Pending tag must keep the stage busy
			if (result.tag != tag) begin
				compare_busy(busy, 1'b1, n);
			end
			@(negedge clock);
		end
		expected.tag = tag;
		expected.rd = table_rows[n].exp_rd;
		expected.inst_rd = 5'(n + 1);
		compare_result(result, expected, n);
		compare_count(read_count - reads_before, table_rows[n].exp_reads, n);
	endtask

	initial begin
		arst_n = 1'b0;
		exec = '0;
		tag = 4'd0;
		row_count = 0;
		result_errors = 0;
		busy_errors = 0;
		count_errors = 0;
		build_table();
		repeat (2) @(posedge clock);
		@(negedge clock);
		arst_n = 1'b1;
		@(negedge clock);
		if (row_count != NUM_ROWS) begin
			$display("stimulus table holds %0d rows instead of %0d", row_count, NUM_ROWS);
			result_errors++;
		end
		for (int n = 0; (n < row_count) && (n < NUM_ROWS); n++) begin
			run_row(n);
		end
		$display("result errors: %0d, busy errors: %0d, bus read count errors: %0d",
			result_errors, busy_errors, count_errors);
		if ((result_errors + busy_errors + count_errors) == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

//--- mem_stage.f
common/mem_pkg.sv
mem_access/mem_access.sv
dcache/dcache.sv
rtl/mem_stage_top.sv
verif/bus_memory_model.sv
verif/tb_mem_stage.sv

//--- Bender.yml
package:
  name: mem_stage

sources:
  # Design sources, package first
  - target: any(rtl, test)
    files:
      - common/mem_pkg.sv
      - mem_access/mem_access.sv
      - dcache/dcache.sv
      - rtl/mem_stage_top.sv

  # Testbench sources
  - target: test
    files:
      - verif/bus_memory_model.sv
      - verif/tb_mem_stage.sv
